// ==== design/itim_array.sv ====
`default_nettype none

module itim_array #(
  parameter int width      = 32,
  parameter int depth_log2 = 4
) (
  input  logic                  clk,
  input  logic                  wen,
  input  logic [depth_log2-1:0] waddr,
  input  logic [width-1:0]      wdata,
  input  logic [depth_log2-1:0] raddr,
  output logic [width-1:0]      rdata
);

  logic [width-1:0] mem [0:2**depth_log2-1];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr]; // Old value on same-index collision
  end

endmodule

`default_nettype wire

// ==== design/itim_ctrl.sv ====
`default_nettype none

module itim_ctrl #(
  parameter int index_bits      = itim_pkg::def_index_bits,
  parameter int line_words_log2 = itim_pkg::def_line_words_log2
) (
  input  logic clk,
  input  logic rst,

  input  logic enable,
  input  logic fence_start,
  output logic fence_busy,
  output logic hit_event,
  output logic refill_event,

  input  logic        fetch_valid,
  input  logic [31:0] fetch_addr,
  output logic [31:0] fetch_rdata,
  output logic        fetch_ready,

  output logic        mem_valid,
  output logic [31:0] mem_addr,
  input  logic [31:0] mem_rdata,
  input  logic        mem_ready,

  output logic [index_bits-1:0]                    tag_raddr,
  output logic [index_bits-1:0]                    tag_waddr,
  output logic                                     tag_wen,
  output logic [30-index_bits-line_words_log2-1:0] tag_wdata,
  input  logic [30-index_bits-line_words_log2-1:0] tag_rdata,

  output logic [index_bits-1:0]               data_raddr,
  output logic [index_bits-1:0]               data_waddr,
  output logic                                data_wen,
  output logic [32*(2**line_words_log2)-1:0]  data_wdata,
  input  logic [32*(2**line_words_log2)-1:0]  data_rdata,

  output logic [index_bits-1:0] lock_raddr,
  output logic [index_bits-1:0] lock_waddr,
  output logic                  lock_wen,
  output logic                  lock_wdata,
  input  logic                  lock_rdata
);

  import itim_pkg::*;

  localparam int tag_bits  = 30 - index_bits - line_words_log2;
  localparam int line_bits = 32 * (2 ** line_words_log2);
  localparam int idx_lo    = line_words_log2 + 2;
  localparam int tag_lo    = index_bits + line_words_log2 + 2;

  itim_state_e state;

  logic [31:0]                req_addr;
  logic [line_words_log2-1:0] refill_cnt;
  logic                       refill_done;
  logic [line_bits-1:0]       line_buf;
  logic [index_bits-1:0]      fence_idx;
  logic                       fence_pend;

  logic [tag_bits-1:0]        req_tag;
  logic [index_bits-1:0]      req_idx;
  logic [line_words_log2-1:0] req_word;
  logic [index_bits-1:0]      fetch_idx;

  logic mem_fire;
  logic lookup_hit;
  logic refill_write;

  // Address split
  assign req_tag   = req_addr[31:tag_lo];
  assign req_idx   = req_addr[tag_lo-1:idx_lo];
  assign req_word  = req_addr[idx_lo-1:2];
  assign fetch_idx = fetch_addr[tag_lo-1:idx_lo];

  assign mem_fire     = mem_valid & mem_ready;
  assign lookup_hit   = (state == LOOKUP) & lock_rdata & (tag_rdata == req_tag);
  assign refill_write = (state == REFILL) & refill_done;

  assign fence_busy   = (state == FENCE);
  assign hit_event    = lookup_hit;
  assign refill_event = refill_write;

  // Arrays are read with the incoming index, sampled in IDLE
  assign tag_raddr  = fetch_idx;
  assign data_raddr = fetch_idx;
  assign lock_raddr = fetch_idx;

  assign tag_waddr  = req_idx;
  assign tag_wen    = refill_write;
  assign tag_wdata  = req_tag;

  assign data_waddr = req_idx;
  assign data_wen   = refill_write;
  assign data_wdata = line_buf;

  // Lock array is shared by refill and the fence sweep
  assign lock_waddr = fence_busy ? fence_idx : req_idx;
  assign lock_wen   = refill_write | fence_busy;
  assign lock_wdata = ~fence_busy;

  always_comb begin
    fetch_ready = 1'b0;
    fetch_rdata = '0;
    case (state)
      LOOKUP: begin
        fetch_ready = lookup_hit;
        fetch_rdata = data_rdata[32*req_word +: 32];
      end
      REFILL: begin
        fetch_ready = refill_done;
        fetch_rdata = line_buf[32*req_word +: 32];
      end
      BYPASS: begin
        fetch_ready = mem_fire; // Word goes straight through
        fetch_rdata = mem_rdata;
      end
      default: begin
        fetch_ready = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state       <= FENCE; // Lock bits unknown until swept
      fence_idx   <= '0;
      fence_pend  <= 1'b0;
      mem_valid   <= 1'b0;
      refill_cnt  <= '0;
      refill_done <= 1'b0;
    end else begin
      if (fence_start && state != IDLE) begin
        fence_pend <= 1'b1;
      end
      case (state)
        IDLE: begin
          if (fence_start || fence_pend) begin
            state      <= FENCE;
            fence_idx  <= '0;
            fence_pend <= 1'b0;
          end else if (fetch_valid) begin
            if (enable) begin
              state <= LOOKUP;
            end else begin
              state     <= BYPASS;
              mem_valid <= 1'b1;
            end
          end
        end
        LOOKUP: begin
          if (lookup_hit) begin
            state <= IDLE;
          end else if (!lock_rdata) begin
            state       <= REFILL;
            mem_valid   <= 1'b1;
            refill_cnt  <= '0;
            refill_done <= 1'b0;
          end else begin
            state     <= BYPASS; // Locked line of another tag stays
            mem_valid <= 1'b1;
          end
        end
        REFILL: begin
          if (refill_done) begin
            state       <= IDLE;
            refill_done <= 1'b0;
          end else if (mem_fire) begin
            refill_cnt <= refill_cnt + 1'b1;
            if (&refill_cnt) begin
              mem_valid   <= 1'b0;
              refill_done <= 1'b1;
            end
          end
        end
        BYPASS: begin
          if (mem_fire) begin
            mem_valid <= 1'b0;
            state     <= IDLE;
          end
        end
        FENCE: begin
          fence_idx <= fence_idx + 1'b1;
          if (&fence_idx) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Request address, backing address and line buffer
  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        req_addr <= fetch_addr;
        mem_addr <= fetch_addr;
      end
      LOOKUP: begin
        if (!lock_rdata) begin
          mem_addr <= {req_addr[31:idx_lo], {idx_lo{1'b0}}}; // Line aligned
        end
      end
      REFILL: begin
        if (mem_fire) begin
          line_buf[32*refill_cnt +: 32] <= mem_rdata;
          mem_addr                      <= mem_addr + 32'd4;
        end
      end
      default: begin
        mem_addr <= mem_addr;
      end
    endcase
  end

  a_mem_addr_stable: assert property (
    @(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr)
  );

  a_ready_needs_valid: assert property (
    @(posedge clk) disable iff (!rst)
    fetch_ready |-> fetch_valid
  );

  a_single_event: assert property (
    @(posedge clk) disable iff (!rst)
    !(hit_event && refill_event)
  );

endmodule

`default_nettype wire

// ==== design/itim_pkg.sv ====
`default_nettype none

package itim_pkg;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    BYPASS,
    FENCE
  } itim_state_e;

  // APB byte offsets
  localparam logic [3:0] reg_ctrl_addr   = 4'h0;
  localparam logic [3:0] reg_status_addr = 4'h4;
  localparam logic [3:0] reg_hit_addr    = 4'h8;
  localparam logic [3:0] reg_refill_addr = 4'hC;

  // Default geometry, 16 lines of 4 words
  localparam int def_index_bits      = 4;
  localparam int def_line_words_log2 = 2;

endpackage

`default_nettype wire

// ==== design/itim_regs.sv ====
`default_nettype none

module itim_regs (
  input  logic        clk,
  input  logic        rst,

  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,

  output logic        enable,
  output logic        fence_start,
  input  logic        fence_busy,
  input  logic        hit_event,
  input  logic        refill_event
);

  import itim_pkg::*;

  logic        access;
  logic        wr_en;
  logic        mapped;
  logic [31:0] hit_count;
  logic [31:0] refill_count;

  assign access  = psel & penable;
  assign wr_en   = access & pwrite;
  assign pready  = 1'b1; // No wait states
  assign mapped  = paddr inside {reg_ctrl_addr, reg_status_addr, reg_hit_addr, reg_refill_addr};
  assign pslverr = access & ~mapped;

  always_ff @(posedge clk) begin
    if (!rst) begin
      enable      <= 1'b1;
      fence_start <= 1'b0;
    end else begin
      fence_start <= wr_en && (paddr == reg_ctrl_addr) && pwdata[1]; // Self clearing
      if (wr_en && paddr == reg_ctrl_addr) begin
        enable <= pwdata[0];
      end
    end
  end

  // Any write clears a counter
  always_ff @(posedge clk) begin
    if (!rst) begin
      hit_count    <= '0;
      refill_count <= '0;
    end else begin
      if (wr_en && paddr == reg_hit_addr) begin
        hit_count <= '0;
      end else if (hit_event) begin
        hit_count <= hit_count + 32'd1;
      end
      if (wr_en && paddr == reg_refill_addr) begin
        refill_count <= '0;
      end else if (refill_event) begin
        refill_count <= refill_count + 32'd1;
      end
    end
  end

  always_comb begin
    case (paddr)
      reg_ctrl_addr:   prdata = {31'd0, enable};
      reg_status_addr: prdata = {31'd0, fence_busy};
      reg_hit_addr:    prdata = hit_count;
      reg_refill_addr: prdata = refill_count;
      default:         prdata = '0;
    endcase
  end

  // Access phase follows a setup phase
  a_slverr_in_access: assert property (
    @(posedge clk) disable iff (!rst)
    pslverr |-> psel && penable && $past(psel && !penable)
  );

endmodule

`default_nettype wire

// ==== design/itim_top.sv ====
`default_nettype none

module itim_top #(
  parameter int index_bits      = itim_pkg::def_index_bits,
  parameter int line_words_log2 = itim_pkg::def_line_words_log2
) (
  input  logic        clk,
  input  logic        rst,

  input  logic        fetch_valid,
  input  logic [31:0] fetch_addr,
  output logic [31:0] fetch_rdata,
  output logic        fetch_ready,

  output logic        mem_valid,
  output logic [31:0] mem_addr,
  input  logic [31:0] mem_rdata,
  input  logic        mem_ready,

  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  localparam int tag_bits  = 30 - index_bits - line_words_log2;
  localparam int line_bits = 32 * (2 ** line_words_log2);

  logic enable;
  logic fence_start;
  logic fence_busy;
  logic hit_event;
  logic refill_event;

  logic [index_bits-1:0] tag_raddr;
  logic [index_bits-1:0] tag_waddr;
  logic                  tag_wen;
  logic [tag_bits-1:0]   tag_wdata;
  logic [tag_bits-1:0]   tag_rdata;

  logic [index_bits-1:0] data_raddr;
  logic [index_bits-1:0] data_waddr;
  logic                  data_wen;
  logic [line_bits-1:0]  data_wdata;
  logic [line_bits-1:0]  data_rdata;

  logic [index_bits-1:0] lock_raddr;
  logic [index_bits-1:0] lock_waddr;
  logic                  lock_wen;
  logic                  lock_wdata;
  logic                  lock_rdata;

  itim_regs u_itim_regs (
    .clk          (clk),
    .rst          (rst),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .enable       (enable),
    .fence_start  (fence_start),
    .fence_busy   (fence_busy),
    .hit_event    (hit_event),
    .refill_event (refill_event)
  );

  itim_ctrl #(
    .index_bits      (index_bits),
    .line_words_log2 (line_words_log2)
  ) u_itim_ctrl (
    .clk          (clk),
    .rst          (rst),
    .enable       (enable),
    .fence_start  (fence_start),
    .fence_busy   (fence_busy),
    .hit_event    (hit_event),
    .refill_event (refill_event),
    .fetch_valid  (fetch_valid),
    .fetch_addr   (fetch_addr),
    .fetch_rdata  (fetch_rdata),
    .fetch_ready  (fetch_ready),
    .mem_valid    (mem_valid),
    .mem_addr     (mem_addr),
    .mem_rdata    (mem_rdata),
    .mem_ready    (mem_ready),
    .tag_raddr    (tag_raddr),
    .tag_waddr    (tag_waddr),
    .tag_wen      (tag_wen),
    .tag_wdata    (tag_wdata),
    .tag_rdata    (tag_rdata),
    .data_raddr   (data_raddr),
    .data_waddr   (data_waddr),
    .data_wen     (data_wen),
    .data_wdata   (data_wdata),
    .data_rdata   (data_rdata),
    .lock_raddr   (lock_raddr),
    .lock_waddr   (lock_waddr),
    .lock_wen     (lock_wen),
    .lock_wdata   (lock_wdata),
    .lock_rdata   (lock_rdata)
  );

  itim_array #(
    .width      (tag_bits),
    .depth_log2 (index_bits)
  ) u_tag_array (
    .clk   (clk),
    .wen   (tag_wen),
    .waddr (tag_waddr),
    .wdata (tag_wdata),
    .raddr (tag_raddr),
    .rdata (tag_rdata)
  );

  // One full line per entry
  itim_array #(
    .width      (line_bits),
    .depth_log2 (index_bits)
  ) u_data_array (
    .clk   (clk),
    .wen   (data_wen),
    .waddr (data_waddr),
    .wdata (data_wdata),
    .raddr (data_raddr),
    .rdata (data_rdata)
  );

  itim_array #(
    .width      (1),
    .depth_log2 (index_bits)
  ) u_lock_array (
    .clk   (clk),
    .wen   (lock_wen),
    .waddr (lock_waddr),
    .wdata (lock_wdata),
    .raddr (lock_raddr),
    .rdata (lock_rdata)
  );

endmodule

`default_nettype wire

// ==== itim_subsys.f ====
design/itim_pkg.sv
design/itim_array.sv
design/itim_ctrl.sv
design/itim_regs.sv
design/itim_top.sv
testbench/itim_checker.sv
testbench/itim_tb.sv

// ==== testbench/itim_checker.sv ====
`default_nettype none

module itim_checker #(
  parameter int index_bits      = itim_pkg::def_index_bits,
  parameter int line_words_log2 = itim_pkg::def_line_words_log2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        fetch_valid,
  input  logic [31:0] fetch_addr,
  input  logic [31:0] fetch_rdata,
  input  logic        fetch_ready,
  input  logic        mem_valid,
  input  logic [31:0] mem_addr,
  input  logic        mem_ready,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  input  logic [31:0] prdata,
  input  logic        pslverr,
  input  logic        check_en,
  input  logic [31:0] row_exp,
  output int          error_count,
  output int          test_count
);

  import itim_pkg::*;

  localparam int depth  = 2 ** index_bits;
  localparam int words  = 2 ** line_words_log2;
  localparam int idx_lo = line_words_log2 + 2;
  localparam int tag_lo = index_bits + idx_lo;

  // Reference copy of lock and tag per index
  logic        lock_m [0:depth-1];
  logic [31:0] tag_m  [0:depth-1];
  logic        enable_m;
  int          hits_m;
  int          refills_m;

  logic        in_fetch;
  logic [31:0] cur_addr;
  itim_state_e cur_kind; // LOOKUP stands for a hit
  int          latency;
  int          n_mem;
  logic [31:0] mem_log [0:words-1];

  initial begin
    error_count = 0;
    test_count  = 0;
    in_fetch    = 1'b0;
  end

  function automatic itim_state_e predict_kind(input logic [31:0] addr);
    int idx;
    idx = (addr >> idx_lo) % depth;
    if (!enable_m) return BYPASS;
    if (!lock_m[idx]) return REFILL;
    if (tag_m[idx] == (addr >> tag_lo)) return LOOKUP;
    return BYPASS; // Locked line of another tag
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic close_fetch();
    int          errs;
    int          idx;
    logic [31:0] base;
    errs = error_count;
    idx  = (cur_addr >> idx_lo) % depth;
    base = (cur_addr >> idx_lo) << idx_lo;
    compare_value("fetch_rdata", fetch_rdata, row_exp);
    case (cur_kind)
      LOOKUP: begin
        compare_value("mem_handshakes", n_mem, 0);
        compare_value("fetch_latency", latency, 1);
        hits_m++;
      end
      REFILL: begin
        compare_value("mem_handshakes", n_mem, words);
        for (int k = 0; k < words && k < n_mem; k++) begin
          compare_value("mem_addr", mem_log[k], base + 4 * k);
        end
        lock_m[idx] = 1'b1;
        tag_m[idx]  = cur_addr >> tag_lo;
        refills_m++;
      end
      default: begin
        compare_value("mem_handshakes", n_mem, 1);
        if (n_mem > 0) begin
          compare_value("mem_addr", mem_log[0], cur_addr);
        end
      end
    endcase
    test_count++;
    $display("test %0d: fetch %h as %s, %s", test_count, cur_addr, cur_kind.name(),
             (errs == error_count) ? "ok" : "mismatch");
  endtask

  task automatic check_read();
    int errs;
    errs = error_count;
    if (paddr inside {reg_ctrl_addr, reg_status_addr, reg_hit_addr, reg_refill_addr}) begin
      compare_value("prdata", prdata, row_exp);
      compare_value("pslverr", pslverr, 1'b0);
      if (paddr == reg_hit_addr) compare_value("hit_count", prdata, hits_m);
      if (paddr == reg_refill_addr) compare_value("refill_count", prdata, refills_m);
    end else begin
      compare_value("pslverr", pslverr, 1'b1); // Unmapped offset
    end
    test_count++;
    $display("test %0d: APB read at %h, %s", test_count, paddr,
             (errs == error_count) ? "ok" : "mismatch");
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < depth; i++) begin
        lock_m[i] = 1'b0; // DUT sweeps locks after reset
      end
      enable_m  = 1'b1;
      hits_m    = 0;
      refills_m = 0;
      in_fetch  = 1'b0;
    end else begin
      if (mem_valid && mem_ready) begin
        if (!in_fetch) begin
          $display("Backing memory access at t=%0t with no fetch open", $time);
          error_count++;
        end else begin
          if (n_mem < words) mem_log[n_mem] = mem_addr;
          n_mem++;
        end
      end
      if (in_fetch) begin
        latency++;
        if (fetch_ready) begin
          close_fetch();
          in_fetch = 1'b0;
        end
      end else begin
        if (fetch_ready) begin
          $display("fetch_ready at t=%0t with no fetch open", $time);
          error_count++;
        end
        if (fetch_valid) begin
          in_fetch = 1'b1;
          cur_addr = fetch_addr;
          cur_kind = predict_kind(fetch_addr);
          latency  = 0;
          n_mem    = 0;
        end
      end
      // APB transfer ends in its access phase
      if (psel && penable) begin
        if (pwrite) begin
          case (paddr)
            reg_ctrl_addr: begin
              enable_m = pwdata[0];
              if (pwdata[1]) begin
                for (int i = 0; i < depth; i++) lock_m[i] = 1'b0;
              end
            end
            reg_hit_addr:    hits_m = 0;
            reg_refill_addr: refills_m = 0;
            default: ;
          endcase
        end else if (check_en) begin
          check_read();
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/itim_tb.sv ====
`default_nettype none

module itim_tb;

  import itim_pkg::*;

  typedef enum logic [1:0] {OP_FETCH, OP_WRITE, OP_READ, OP_FENCE_WAIT} op_e;

  localparam int wait_limit  = 50;
  localparam int fence_polls = 40;

  logic        clk;
  logic        rst;
  logic        fetch_valid;
  logic [31:0] fetch_addr;
  logic [31:0] fetch_rdata;
  logic        fetch_ready;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic        check_en;
  logic [31:0] row_exp;
  logic [31:0] apb_rdata;
  int          error_count;
  int          test_count;
  bit          timed_out;
  integer      seed = 53499;

  op_e         op_q    [$];
  logic [31:0] addr_q  [$];
  logic [31:0] wdata_q [$];
  logic [31:0] exp_q   [$];

  itim_top u_itim_top (
    .clk (clk), .rst (rst),
    .fetch_valid (fetch_valid), .fetch_addr (fetch_addr),
    .fetch_rdata (fetch_rdata), .fetch_ready (fetch_ready),
    .mem_valid (mem_valid), .mem_addr (mem_addr),
    .mem_rdata (mem_rdata), .mem_ready (mem_ready),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr)
  );

  itim_checker u_checker (
    .clk (clk), .rst (rst),
    .fetch_valid (fetch_valid), .fetch_addr (fetch_addr),
    .fetch_rdata (fetch_rdata), .fetch_ready (fetch_ready),
    .mem_valid (mem_valid), .mem_addr (mem_addr), .mem_ready (mem_ready),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .prdata (prdata), .pslverr (pslverr),
    .check_en (check_en), .row_exp (row_exp),
    .error_count (error_count), .test_count (test_count)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Backing word for byte address of the word
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'hC0DE_0000;
  endfunction

  initial begin : backing_memory
    bit fire;
    bit armed;
    int wait_left;
    mem_ready = 1'b0;
    mem_rdata = '0;
    armed     = 1'b0;
    wait_left = 0;
    forever begin
      @(posedge clk);
      fire = mem_valid && mem_ready;
      #1;
      if (fire) begin
        mem_ready = 1'b0;
        armed     = 1'b0;
      end
      if (mem_valid && !mem_ready) begin
        if (!armed) begin
          wait_left = $unsigned($random(seed)) % 4; // 0 to 3 stall cycles
          armed     = 1'b1;
        end
        if (wait_left == 0) begin
          mem_ready = 1'b1;
          mem_rdata = mem_word(mem_addr);
        end else begin
          wait_left--;
        end
      end
    end
  end

  task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [31:0] exp);
    op_q.push_back(op);
    addr_q.push_back(addr);
    wdata_q.push_back(wdata);
    exp_q.push_back(exp);
  endtask

  task automatic apb_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata);
    int cycles;
    bit done;
    cycles  = 0;
    done    = 1'b0;
    rdata   = '0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk); // Setup phase
    #1;
    penable = 1'b1;
    while (!done && !timed_out) begin
      @(posedge clk);
      if (pready) begin
        done  = 1'b1;
        rdata = prdata;
      end else begin
        cycles++;
        if (cycles >= wait_limit) begin
          $display("Timeout: APB transfer at offset %h never completed", addr);
          timed_out = 1'b1;
        end
      end
    end
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic run_fetch(input logic [31:0] addr);
    int cycles;
    bit done;
    cycles      = 0;
    done        = 1'b0;
    fetch_valid = 1'b1;
    fetch_addr  = addr;
    while (!done && !timed_out) begin
      @(posedge clk);
      if (fetch_ready) begin
        done = 1'b1;
      end else begin
        cycles++;
        if (cycles >= wait_limit) begin
          $display("Timeout: fetch of %h got no fetch_ready", addr);
          timed_out = 1'b1;
        end
      end
    end
    #1;
    fetch_valid = 1'b0;
  endtask

  task automatic wait_fence_done();
    logic [31:0] status;
    int          polls;
    polls    = 0;
    status   = 32'd1;
    check_en = 1'b0; // Poll reads are not tests
    while (status[0] && !timed_out) begin
      apb_transfer(1'b0, reg_status_addr, 32'd0, status);
      polls++;
      if (status[0] && polls >= fence_polls) begin
        $display("Timeout: STATUS still busy after %0d polls", polls);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic build_table();
    add_row(OP_FENCE_WAIT, 0, 0, 0); // Sweep after reset
    add_row(OP_READ, reg_ctrl_addr, 0, 32'd1);
    // Cold line, then another word of it
    add_row(OP_FETCH, 32'h0000_1004, 0, mem_word(32'h0000_1004));
    add_row(OP_FETCH, 32'h0000_1008, 0, mem_word(32'h0000_1008));
    add_row(OP_READ, reg_refill_addr, 0, 32'd1);
    add_row(OP_READ, reg_hit_addr, 0, 32'd1);
    // Same index, other tag
    add_row(OP_FETCH, 32'h0000_2000, 0, mem_word(32'h0000_2000));
    add_row(OP_FETCH, 32'h0000_100C, 0, mem_word(32'h0000_100C));
    add_row(OP_READ, reg_hit_addr, 0, 32'd2);
    add_row(OP_READ, reg_refill_addr, 0, 32'd1);
    add_row(OP_FETCH, 32'h0000_1050, 0, mem_word(32'h0000_1050));
    add_row(OP_READ, reg_refill_addr, 0, 32'd2);
    // Fence keeps enable set
    add_row(OP_WRITE, reg_ctrl_addr, 32'h3, 0);
    add_row(OP_READ, reg_status_addr, 0, 32'd1);
    add_row(OP_FENCE_WAIT, 0, 0, 0);
    add_row(OP_READ, reg_status_addr, 0, 32'd0);
    add_row(OP_READ, reg_ctrl_addr, 0, 32'd1);
    add_row(OP_FETCH, 32'h0000_1000, 0, mem_word(32'h0000_1000));
    add_row(OP_FETCH, 32'h0000_1054, 0, mem_word(32'h0000_1054));
    add_row(OP_READ, reg_refill_addr, 0, 32'd4);
    add_row(OP_WRITE, reg_hit_addr, 32'hFFFF_FFFF, 0);
    add_row(OP_WRITE, reg_refill_addr, 32'h0000_00A5, 0);
    add_row(OP_READ, reg_hit_addr, 0, 32'd0);
    add_row(OP_READ, reg_refill_addr, 0, 32'd0);
    // Disabled, everything passes through
    add_row(OP_WRITE, reg_ctrl_addr, 32'h0, 0);
    add_row(OP_READ, reg_ctrl_addr, 0, 32'd0);
    add_row(OP_FETCH, 32'h0000_1000, 0, mem_word(32'h0000_1000));
    add_row(OP_FETCH, 32'h0000_3030, 0, mem_word(32'h0000_3030));
    add_row(OP_FETCH, 32'h0000_3034, 0, mem_word(32'h0000_3034));
    add_row(OP_READ, reg_hit_addr, 0, 32'd0);
    add_row(OP_READ, reg_refill_addr, 0, 32'd0);
    add_row(OP_WRITE, reg_ctrl_addr, 32'h1, 0);
    add_row(OP_FETCH, 32'h0000_1008, 0, mem_word(32'h0000_1008));
    add_row(OP_READ, reg_hit_addr, 0, 32'd1);
    add_row(OP_READ, 32'h2, 0, 32'd0); // Unmapped offset
  endtask

  initial begin
    rst         = 1'b0;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    check_en    = 1'b0;
    row_exp     = '0;
    timed_out   = 1'b0;
    build_table();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b1;
    for (int i = 0; i < op_q.size(); i++) begin
      if (timed_out) break;
      row_exp  = exp_q[i];
      check_en = (op_q[i] == OP_READ);
      case (op_q[i])
        OP_FETCH: run_fetch(addr_q[i]);
        OP_WRITE: apb_transfer(1'b1, addr_q[i][3:0], wdata_q[i], apb_rdata);
        OP_READ:  apb_transfer(1'b0, addr_q[i][3:0], 32'd0, apb_rdata);
        default:  wait_fence_done();
      endcase
    end
    repeat (2) @(posedge clk);
    $display("Tests run: %0d, errors: %0d, timeout: %0d", test_count, error_count, timed_out);
    if (error_count == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
